// File: design/rp_adc_frontend.sv
// ----------------------------------------
// ADC front end, offset binary to signed
// with saturating negate on both channels
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_adc_frontend import rp_radar_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  logic [`RP_ADC_W-1:0] adc_dat_a_i,   // ch A, offset binary
   input  logic [`RP_ADC_W-1:0] adc_dat_b_i,   // ch B, offset binary
   input  logic                 adc_neg_a_i,   // video negate
   output adc_sample_t          adc_a_o,
   output adc_sample_t          adc_b_o
);

   localparam adc_sample_t MOST_NEG = {1'b1, {(`RP_ADC_W-1){1'b0}}};
   localparam adc_sample_t MOST_POS = ~MOST_NEG;

   adc_sample_t conv_a;   // after msb flip
   adc_sample_t conv_b;

   // most negative code has no positive twin, clip it
   function automatic adc_sample_t neg_sat(input adc_sample_t s);
      return (s == MOST_NEG) ? MOST_POS : -s;
   endfunction

   assign conv_a = {~adc_dat_a_i[`RP_ADC_W-1], adc_dat_a_i[`RP_ADC_W-2:0]};   // flip msb
   assign conv_b = {~adc_dat_b_i[`RP_ADC_W-1], adc_dat_b_i[`RP_ADC_W-2:0]};

   always_ff @(posedge adc_clk) begin
      if (rst_i) begin
         adc_a_o <= '0;
         adc_b_o <= '0;
      end else begin
         adc_a_o <= adc_neg_a_i ? neg_sat(conv_a) : conv_a;
         adc_b_o <= neg_sat(conv_b);   // ch B always inverted
      end
   end

endmodule

// File: design/rp_bus_pkg.sv
// ----------------------------------------
// system bus region type
// address word with raw and field views
// ----------------------------------------
`include "rp_config.svh"

package rp_bus_pkg;

   typedef logic [2:0] sys_region_t;   // one of eight regions

   // decoder looks at region, peripherals at offset
   typedef union packed {
      logic [`RP_BUS_W-1:0] raw;                      // as driven by master
      struct packed {
         logic [`RP_BUS_W-`RP_REGION_LSB-4:0] unused; // above region
         sys_region_t                         region; // selects peripheral
         logic [`RP_REGION_LSB-1:0]           offset; // register offset
      } f;
   } sys_addr_u;

endpackage

// File: design/rp_config.svh
// ----------------------------------------
// widths, bus regions and register offsets
// ID word and scope buffer sizing
// ----------------------------------------
`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

`define RP_ADC_W           14              // fast ADC sample bits
`define RP_BUS_W           32              // sys bus address and data
`define RP_REGION_LSB      20              // region field starts here
`define RP_REGION_HK       3'd0
`define RP_REGION_SCOPE    3'd1
`define RP_REGION_TRIG     3'd6
`define RP_HK_ID           32'h5250_0A01   // board ID word
`define RP_SCOPE_DEPTH     256             // samples in capture buffer
`define RP_SCOPE_BUF_BASE  20'h10000       // start of buffer window

// housekeeping, region 0
`define RP_HK_ID_OFS       20'h00000
`define RP_HK_LED_OFS      20'h00030
// radar trigger, region 6
`define RP_TRIG_THR_OFS    20'h00000
`define RP_TRIG_DLY_OFS    20'h00004
`define RP_TRIG_NEG_OFS    20'h00008
`define RP_TRIG_CNT_OFS    20'h0000C
// scope, region 1
`define RP_SCOPE_CTRL_OFS  20'h00000
`define RP_SCOPE_LEN_OFS   20'h00004
`define RP_SCOPE_STAT_OFS  20'h00008

`endif

// File: design/rp_housekeeping.sv
// ----------------------------------------
// housekeeping, ID word and LED register
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_housekeeping import rp_bus_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  logic [`RP_BUS_W-1:0] sys_addr_i,
   input  logic [`RP_BUS_W-1:0] sys_wdata_i,
   input  logic                 sys_wen_i,
   input  logic                 sys_ren_i,
   output logic [`RP_BUS_W-1:0] sys_rdata_o,
   output logic                 sys_ack_o,
   output logic                 sys_err_o,
   output logic [7:0]           led_o         // LED register
);

   sys_addr_u addr;

   assign addr.raw  = sys_addr_i;
   assign sys_err_o = 1'b0;   // every offset is legal

   always_ff @(posedge adc_clk) begin
      if (rst_i) begin
         sys_ack_o <= 1'b0;
         led_o     <= '0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;   // one cycle answer
         if (sys_wen_i && addr.f.offset == `RP_HK_LED_OFS)
            led_o <= sys_wdata_i[7:0];
      end
   end

   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         case (addr.f.offset)
            `RP_HK_ID_OFS:  sys_rdata_o <= `RP_HK_ID;
            `RP_HK_LED_OFS: sys_rdata_o <= {{(`RP_BUS_W-8){1'b0}}, led_o};   // upper bits zero
            default:        sys_rdata_o <= '0;
         endcase
      end
   end

endmodule

// File: design/rp_radar_pkg.sv
// ----------------------------------------
// sample type for front end, trigger, scope
// ----------------------------------------
`include "rp_config.svh"

package rp_radar_pkg;

   typedef logic signed [`RP_ADC_W-1:0] adc_sample_t;   // two's complement

endpackage

// File: design/rp_radar_trigger.sv
// ----------------------------------------
// radar trigger from ch B crossings
// delay counter, crossing count, negate
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_radar_trigger import rp_bus_pkg::*, rp_radar_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  adc_sample_t          adc_b_i,       // trigger channel
   input  logic                 adc_ready_i,   // scope waiting for trigger
   input  logic [`RP_BUS_W-1:0] sys_addr_i,
   input  logic [`RP_BUS_W-1:0] sys_wdata_i,
   input  logic                 sys_wen_i,
   input  logic                 sys_ren_i,
   output logic [`RP_BUS_W-1:0] sys_rdata_o,
   output logic                 sys_ack_o,
   output logic                 sys_err_o,
   output logic                 radar_trig_o,  // one cycle pulse
   output logic                 adc_neg_a_o    // video negate
);

   sys_addr_u            addr;
   adc_sample_t          thr_q;       // crossing threshold
   adc_sample_t          adc_b_q;     // previous sample
   logic [15:0]          dly_q;       // programmed delay
   logic [15:0]          dly_cnt;
   logic                 busy;        // delay running
   logic [`RP_BUS_W-1:0] cross_cnt;
   logic                 crossing;
   logic                 counted;

   assign addr.raw  = sys_addr_i;
   assign sys_err_o = 1'b0;
   assign crossing  = (adc_b_i >= thr_q) && (adc_b_q < thr_q);   // rising through thr
   assign counted   = crossing && adc_ready_i;

   // ----------------------------------------
   // bus registers
   always_ff @(posedge adc_clk) begin
      if (rst_i) begin
         sys_ack_o   <= 1'b0;
         thr_q       <= '0;
         dly_q       <= '0;
         adc_neg_a_o <= 1'b0;
         cross_cnt   <= '0;
         adc_b_q     <= '0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;
         adc_b_q   <= adc_b_i;
         if (counted)
            cross_cnt <= cross_cnt + 1'b1;
         if (sys_wen_i) begin
            case (addr.f.offset)
               `RP_TRIG_THR_OFS: thr_q       <= sys_wdata_i[`RP_ADC_W-1:0];
               `RP_TRIG_DLY_OFS: dly_q       <= sys_wdata_i[15:0];
               `RP_TRIG_NEG_OFS: adc_neg_a_o <= sys_wdata_i[0];
               `RP_TRIG_CNT_OFS: cross_cnt   <= '0;   // clear beats a crossing
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         case (addr.f.offset)
            `RP_TRIG_THR_OFS: sys_rdata_o <= {{(`RP_BUS_W-`RP_ADC_W){thr_q[`RP_ADC_W-1]}}, thr_q};
            `RP_TRIG_DLY_OFS: sys_rdata_o <= {{(`RP_BUS_W-16){1'b0}}, dly_q};
            `RP_TRIG_NEG_OFS: sys_rdata_o <= {{(`RP_BUS_W-1){1'b0}}, adc_neg_a_o};
            `RP_TRIG_CNT_OFS: sys_rdata_o <= cross_cnt;
            default:          sys_rdata_o <= '0;
         endcase
      end
   end

   // ----------------------------------------
   // delay counter, fires delay+1 after crossing
   always_ff @(posedge adc_clk) begin
      if (rst_i) begin
         busy         <= 1'b0;
         dly_cnt      <= '0;
         radar_trig_o <= 1'b0;
      end else begin
         radar_trig_o <= 1'b0;
         if (busy) begin
            dly_cnt <= dly_cnt - 1'b1;
            if (dly_cnt == 16'd1) begin
               busy         <= 1'b0;
               radar_trig_o <= 1'b1;
            end
         end else if (counted && !radar_trig_o) begin
            if (dly_q == '0) begin
               radar_trig_o <= 1'b1;   // no delay, next cycle
            end else begin
               busy    <= 1'b1;
               dly_cnt <= dly_q;
            end
         end
      end
   end

   a_trig_single: assert property (@(posedge adc_clk) disable iff (rst_i)
      radar_trig_o |=> !radar_trig_o);

endmodule

// File: design/rp_scope_capture.sv
// ----------------------------------------
// scope, arm and trigger FSM on ch A
// capture buffer and status registers
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_scope_capture import rp_bus_pkg::*, rp_radar_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  adc_sample_t          adc_a_i,        // video channel
   input  logic                 radar_trig_i,
   input  logic [`RP_BUS_W-1:0] sys_addr_i,
   input  logic [`RP_BUS_W-1:0] sys_wdata_i,
   input  logic                 sys_wen_i,
   input  logic                 sys_ren_i,
   output logic [`RP_BUS_W-1:0] sys_rdata_o,
   output logic                 sys_ack_o,
   output logic                 sys_err_o,
   output logic                 adc_ready_o     // armed, not triggered
);

   localparam int             IDX_W   = $clog2(`RP_SCOPE_DEPTH);
   localparam logic [IDX_W:0] DEPTH   = `RP_SCOPE_DEPTH;
   localparam logic [1:0]     S_IDLE  = 2'd0;
   localparam logic [1:0]     S_ARMED = 2'd1;
   localparam logic [1:0]     S_CAPT  = 2'd2;

   sys_addr_u      addr;
   logic [1:0]     state;
   logic           done;                          // status bit 1
   logic           radar_en;                      // ctrl bit 2
   logic [IDX_W:0] len_q;                         // post-trigger length
   logic [IDX_W:0] widx;                          // write index
   logic           ctrl_wr;
   logic           trig;
   logic           buf_hit;                       // read inside buffer window
   adc_sample_t    buf_mem [`RP_SCOPE_DEPTH];
   adc_sample_t    buf_rd;

   assign addr.raw    = sys_addr_i;
   assign sys_err_o   = 1'b0;
   assign adc_ready_o = (state == S_ARMED);
   assign ctrl_wr     = sys_wen_i && (addr.f.offset == `RP_SCOPE_CTRL_OFS);
   assign trig        = (ctrl_wr && sys_wdata_i[1]) || (radar_en && radar_trig_i);
   assign buf_hit     = (addr.f.offset >= `RP_SCOPE_BUF_BASE) &&
                        (addr.f.offset < `RP_SCOPE_BUF_BASE + 4 * `RP_SCOPE_DEPTH);
   assign buf_rd      = buf_mem[addr.f.offset[IDX_W+1:2]];   // word index

   // ----------------------------------------
   // control registers and FSM
   always_ff @(posedge adc_clk) begin
      if (rst_i) begin
         sys_ack_o <= 1'b0;
         state     <= S_IDLE;
         done      <= 1'b0;
         radar_en  <= 1'b0;
         len_q     <= '0;
         widx      <= '0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;
         if (sys_wen_i && addr.f.offset == `RP_SCOPE_LEN_OFS)
            len_q <= (sys_wdata_i > `RP_SCOPE_DEPTH) ? DEPTH : sys_wdata_i[IDX_W:0];   // clamp
         if (ctrl_wr)
            radar_en <= sys_wdata_i[2];
         if (ctrl_wr && sys_wdata_i[0]) begin   // arm restarts from any state
            state <= sys_wdata_i[1] ? S_CAPT : S_ARMED;
            done  <= 1'b0;
            widx  <= '0;
         end else begin
            case (state)
               S_ARMED: if (trig) state <= S_CAPT;
               S_CAPT: begin
                  if (widx + 1'b1 >= len_q) begin   // last sample
                     state <= S_IDLE;
                     done  <= 1'b1;
                  end else begin
                     widx <= widx + 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge adc_clk) begin
      if (state == S_CAPT)
         buf_mem[widx[IDX_W-1:0]] <= adc_a_i;
   end

   // ----------------------------------------
   // read data, buffer or registers
   always_ff @(posedge adc_clk) begin
      if (sys_ren_i) begin
         if (buf_hit) begin
            sys_rdata_o <= {{(`RP_BUS_W-`RP_ADC_W){buf_rd[`RP_ADC_W-1]}}, buf_rd};   // sign ext
         end else begin
            case (addr.f.offset)
               `RP_SCOPE_CTRL_OFS: sys_rdata_o <= {{(`RP_BUS_W-3){1'b0}}, radar_en, 2'b00};
               `RP_SCOPE_LEN_OFS:  sys_rdata_o <= {{(`RP_BUS_W-IDX_W-1){1'b0}}, len_q};
               `RP_SCOPE_STAT_OFS: sys_rdata_o <= {{(`RP_BUS_W-2){1'b0}}, done, adc_ready_o};
               default:            sys_rdata_o <= '0;
            endcase
         end
      end
   end

   // length clamp keeps the capture inside the buffer
   a_widx_in_range: assert property (@(posedge adc_clk) disable iff (rst_i)
      widx < DEPTH);

endmodule

// File: design/rp_sys_bus_decoder.sv
// ----------------------------------------
// system bus decoder, eight regions
// strobe routing, response mux, error
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_sys_bus_decoder import rp_bus_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  logic [`RP_BUS_W-1:0] sys_addr_i,      // held until ack
   input  logic                 sys_wen_i,
   input  logic                 sys_ren_i,
   output logic [`RP_BUS_W-1:0] sys_rdata_o,
   output logic                 sys_ack_o,
   output logic                 sys_err_o,
   output logic                 hk_wen_o,        // region 0
   output logic                 hk_ren_o,
   input  logic [`RP_BUS_W-1:0] hk_rdata_i,
   input  logic                 hk_ack_i,
   input  logic                 hk_err_i,
   output logic                 scope_wen_o,     // region 1
   output logic                 scope_ren_o,
   input  logic [`RP_BUS_W-1:0] scope_rdata_i,
   input  logic                 scope_ack_i,
   input  logic                 scope_err_i,
   output logic                 trig_wen_o,      // region 6
   output logic                 trig_ren_o,
   input  logic [`RP_BUS_W-1:0] trig_rdata_i,
   input  logic                 trig_ack_i,
   input  logic                 trig_err_i
);

   sys_addr_u addr;
   logic      hk_sel;
   logic      scope_sel;
   logic      trig_sel;
   logic      none_sel;   // unmapped region
   logic      none_ack;   // own ack and err for unmapped access

   assign addr.raw = sys_addr_i;

   always_comb begin
      hk_sel    = 1'b0;
      scope_sel = 1'b0;
      trig_sel  = 1'b0;
      none_sel  = 1'b0;
      case (addr.f.region)
         `RP_REGION_HK:    hk_sel    = 1'b1;
         `RP_REGION_SCOPE: scope_sel = 1'b1;
         `RP_REGION_TRIG:  trig_sel  = 1'b1;
         default:          none_sel  = 1'b1;   // 2..5 and 7
      endcase
   end

   assign hk_wen_o    = hk_sel    & sys_wen_i;
   assign hk_ren_o    = hk_sel    & sys_ren_i;
   assign scope_wen_o = scope_sel & sys_wen_i;
   assign scope_ren_o = scope_sel & sys_ren_i;
   assign trig_wen_o  = trig_sel  & sys_wen_i;
   assign trig_ren_o  = trig_sel  & sys_ren_i;

   always_ff @(posedge adc_clk) begin
      if (rst_i)
         none_ack <= 1'b0;
      else
         none_ack <= none_sel & (sys_wen_i | sys_ren_i);
   end

   // ----------------------------------------
   // response mux, by region of held address
   always_comb begin
      sys_rdata_o = '0;
      sys_ack_o   = none_ack;
      sys_err_o   = none_ack;   // unmapped answers with error
      if (hk_sel) begin
         sys_rdata_o = hk_rdata_i;
         sys_ack_o   = hk_ack_i;
         sys_err_o   = hk_err_i;
      end else if (scope_sel) begin
         sys_rdata_o = scope_rdata_i;
         sys_ack_o   = scope_ack_i;
         sys_err_o   = scope_err_i;
      end else if (trig_sel) begin
         sys_rdata_o = trig_rdata_i;
         sys_ack_o   = trig_ack_i;
         sys_err_o   = trig_err_i;
      end
   end

   // every ack answers a strobe of the cycle before
   a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
      sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

   // one request at a time, no new strobe in the ack cycle
   a_one_outstanding: assert property (@(posedge adc_clk) disable iff (rst_i)
      (sys_wen_i || sys_ren_i) |=> !(sys_wen_i || sys_ren_i));

endmodule

// File: design/rp_top.sv
// ----------------------------------------
// fast ADC top, front end, bus decoder
// housekeeping, scope and radar trigger
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_top import rp_radar_pkg::*; (
   input  logic                 adc_clk,
   input  logic                 rst_i,
   input  logic [`RP_ADC_W-1:0] adc_dat_a_i,   // ch A, video
   input  logic [`RP_ADC_W-1:0] adc_dat_b_i,   // ch B, trigger
   input  logic [`RP_BUS_W-1:0] sys_addr_i,
   input  logic [`RP_BUS_W-1:0] sys_wdata_i,
   input  logic                 sys_wen_i,
   input  logic                 sys_ren_i,
   output logic [`RP_BUS_W-1:0] sys_rdata_o,
   output logic                 sys_ack_o,
   output logic                 sys_err_o,
   output logic [7:0]           led_o
);

   adc_sample_t          adc_a;
   adc_sample_t          adc_b;
   logic                 adc_neg_a;
   logic                 radar_trig;
   logic                 adc_ready;
   logic                 hk_wen,    hk_ren,    hk_ack,    hk_err;
   logic                 scope_wen, scope_ren, scope_ack, scope_err;
   logic                 trig_wen,  trig_ren,  trig_ack,  trig_err;
   logic [`RP_BUS_W-1:0] hk_rdata;
   logic [`RP_BUS_W-1:0] scope_rdata;
   logic [`RP_BUS_W-1:0] trig_rdata;

   rp_adc_frontend i_frontend (
      .adc_clk, .rst_i, .adc_dat_a_i, .adc_dat_b_i,
      .adc_neg_a_i  (adc_neg_a),     // from trigger block
      .adc_a_o      (adc_a),
      .adc_b_o      (adc_b)
   );

   rp_sys_bus_decoder i_decoder (
      .adc_clk, .rst_i, .sys_addr_i, .sys_wen_i, .sys_ren_i,
      .sys_rdata_o, .sys_ack_o, .sys_err_o,
      .hk_wen_o      (hk_wen),      .hk_ren_o      (hk_ren),
      .hk_rdata_i    (hk_rdata),    .hk_ack_i      (hk_ack),    .hk_err_i    (hk_err),
      .scope_wen_o   (scope_wen),   .scope_ren_o   (scope_ren),
      .scope_rdata_i (scope_rdata), .scope_ack_i   (scope_ack), .scope_err_i (scope_err),
      .trig_wen_o    (trig_wen),    .trig_ren_o    (trig_ren),
      .trig_rdata_i  (trig_rdata),  .trig_ack_i    (trig_ack),  .trig_err_i  (trig_err)
   );

   rp_housekeeping i_hk (
      .adc_clk, .rst_i, .sys_addr_i, .sys_wdata_i,
      .sys_wen_i   (hk_wen),
      .sys_ren_i   (hk_ren),
      .sys_rdata_o (hk_rdata),
      .sys_ack_o   (hk_ack),
      .sys_err_o   (hk_err),
      .led_o
   );

   rp_scope_capture i_scope (
      .adc_clk, .rst_i, .sys_addr_i, .sys_wdata_i,
      .adc_a_i      (adc_a),
      .radar_trig_i (radar_trig),
      .sys_wen_i    (scope_wen),
      .sys_ren_i    (scope_ren),
      .sys_rdata_o  (scope_rdata),
      .sys_ack_o    (scope_ack),
      .sys_err_o    (scope_err),
      .adc_ready_o  (adc_ready)     // gates crossing count
   );

   rp_radar_trigger i_trig (
      .adc_clk, .rst_i, .sys_addr_i, .sys_wdata_i,
      .adc_b_i      (adc_b),
      .adc_ready_i  (adc_ready),
      .sys_wen_i    (trig_wen),
      .sys_ren_i    (trig_ren),
      .sys_rdata_o  (trig_rdata),
      .sys_ack_o    (trig_ack),
      .sys_err_o    (trig_err),
      .radar_trig_o (radar_trig),
      .adc_neg_a_o  (adc_neg_a)
   );

endmodule

// File: tb.f
+incdir+design
design/rp_bus_pkg.sv
design/rp_radar_pkg.sv
design/rp_adc_frontend.sv
design/rp_sys_bus_decoder.sv
design/rp_housekeeping.sv
design/rp_radar_trigger.sv
design/rp_scope_capture.sv
design/rp_top.sv
verif/tb_rp_top.sv

// File: verif/rp_golden.txt
# columns: test op address data, address and data in hex
# ops wr rd rderr led wait slope ramp; wait data is a status mask, slope data is count<<16 | step
hk_id_led rd 00000000 52500a01
hk_id_led wr 00000030 000003a5
hk_id_led led 00000000 000000a5
hk_id_led rd 00000030 000000a5
unmapped rderr 00300000 00000001
sw_capture wr 00100004 00000020
sw_capture wr 00100000 00000003
sw_capture wait 00100008 00000002
sw_capture slope 00110000 00200001
video_negate wr 00600008 00000001
video_negate wr 00100004 00000020
video_negate wr 00100000 00000003
video_negate wait 00100008 00000002
video_negate slope 00110000 00203fff
radar_cross ramp 00000000 00000028
radar_cross wr 00600000 00000014
radar_cross wr 00600004 00000005
radar_cross wr 00100004 00000010
radar_cross wr 00100000 00000005
radar_cross wait 00100008 00000002
radar_cross rd 0060000c 00000001
count_clear wr 0060000c 00000000
count_clear rd 0060000c 00000000

// File: verif/tb_rp_top.sv
// ----------------------------------------
// testbench for the fast ADC top
// golden file driven bus and ADC stimulus
// ----------------------------------------
`timescale 1ns/1ps
`include "rp_config.svh"

module tb_rp_top;

   localparam int MAX_OPS = 64;

   logic                 adc_clk;
   logic                 rst_i;
   logic [`RP_ADC_W-1:0] adc_dat_a_i;
   logic [`RP_ADC_W-1:0] adc_dat_b_i;
   logic [`RP_BUS_W-1:0] sys_addr_i;
   logic [`RP_BUS_W-1:0] sys_wdata_i;
   logic                 sys_wen_i;
   logic                 sys_ren_i;
   logic [`RP_BUS_W-1:0] sys_rdata_o;
   logic                 sys_ack_o;
   logic                 sys_err_o;
   logic [7:0]           led_o;

   reg [8*16-1:0] t_name [MAX_OPS];   // golden file columns
   reg [8*8-1:0]  t_op   [MAX_OPS];
   reg [31:0]     t_addr [MAX_OPS];
   reg [31:0]     t_data [MAX_OPS];
   integer        n_ops;
   integer        budget;             // op count plus lengths
   integer        limit     = 0;      // 0 until golden file is loaded
   integer        cycles    = 0;
   integer        errors    = 0;
   integer        test_errs = 0;
   integer        tests     = 0;
   integer        failed    = 0;
   integer        b_period  = 0;      // ch B sawtooth period, 0 is flat
   integer        b_k       = 0;      // ch B sawtooth phase

   rp_top rp_top_inst (.*);

   always #4 adc_clk = ~adc_clk;      // 8 ns

   // ----------------------------------------
   // ADC stimulus
   always @(posedge adc_clk) begin
      adc_dat_a_i <= adc_dat_a_i + 1'b1;                       // counting ramp
      b_k         <= (b_period == 0) ? 0 : (b_k + 1) % b_period;
      adc_dat_b_i <= 14'h2000 - b_k[`RP_ADC_W-1:0];           // reads back as +k after negate
   end

   // run guard
   always @(posedge adc_clk) begin
      cycles = cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("timeout: no progress after %0d cycles, DUT did not respond", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic check_value(input reg [8*16-1:0] name, input reg [31:0] exp,
                              input reg [31:0] act);
      if (exp !== act) begin
         $display("MISMATCH %0s expected %h actual %h", name, exp, act);
         errors    = errors + 1;
         test_errs = test_errs + 1;
      end
   endtask

   // one strobe, then hold the address until ack
   task automatic bus_access(input bit wr, input reg [31:0] a, input reg [31:0] wd,
                             output reg [31:0] rd, output bit err);
      @(posedge adc_clk);
      sys_addr_i  <= a;
      sys_wdata_i <= wd;
      sys_wen_i   <= wr;
      sys_ren_i   <= !wr;
      @(posedge adc_clk);
      sys_wen_i   <= 1'b0;
      sys_ren_i   <= 1'b0;
      @(negedge adc_clk);
      while (!sys_ack_o)
         @(negedge adc_clk);
      rd  = sys_rdata_o;
      err = sys_err_o;
   endtask

   task automatic load_golden(output bit ok);
      integer        fd;
      integer        n;
      integer        c;
      reg [8*16-1:0] tok;
      reg [8*8-1:0]  op;
      reg [31:0]     a;
      reg [31:0]     d;
      ok     = 1'b0;
      n_ops  = 0;
      budget = 0;
      fd = $fopen("verif/rp_golden.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin                // comment line
               c = $fgetc(fd);
               while (c != "\n" && c != -1)
                  c = $fgetc(fd);
            end else begin
               n = $fscanf(fd, "%s %h %h", op, a, d);
               if (n != 3 || n_ops >= MAX_OPS) begin
                  $display("golden file line for %0s is malformed or too many lines", tok);
                  ok = 1'b0;
               end else begin
                  t_name[n_ops] = tok;
                  t_op[n_ops]   = op;
                  t_addr[n_ops] = a;
                  t_data[n_ops] = d;
                  n_ops  = n_ops + 1;
                  budget = budget + 1;
                  if (op == "wr" && a == 32'h0010_0004)
                     budget = budget + d;          // capture length
                  if (op == "slope")
                     budget = budget + d[31:16];   // entries read
                  if (op == "ramp")
                     budget = budget + d;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_op(input integer i);
      reg [31:0] rd;
      reg [31:0] prev;
      bit        err;
      integer    j;
      case (t_op[i])
         "wr": begin
            bus_access(1'b1, t_addr[i], t_data[i], rd, err);
            check_value(t_name[i], 32'd0, {31'd0, err});
         end
         "rd": begin
            bus_access(1'b0, t_addr[i], 32'd0, rd, err);
            check_value(t_name[i], t_data[i], rd);
            check_value(t_name[i], 32'd0, {31'd0, err});
         end
         "rderr": begin
            bus_access(1'b0, t_addr[i], 32'd0, rd, err);
            check_value(t_name[i], t_data[i], {31'd0, err});
         end
         "led": begin
            @(negedge adc_clk);
            check_value(t_name[i], t_data[i], {24'd0, led_o});
         end
         "wait": begin                             // poll status until mask set
            rd = 32'd0;
            while ((rd & t_data[i]) != t_data[i])
               bus_access(1'b0, t_addr[i], 32'd0, rd, err);
         end
         "slope": begin                            // step between buffer entries
            prev = 32'd0;
            for (j = 0; j < t_data[i][31:16]; j = j + 1) begin
               bus_access(1'b0, t_addr[i] + 4 * j, 32'd0, rd, err);
               if (j > 0)
                  check_value(t_name[i], {18'd0, t_data[i][`RP_ADC_W-1:0]},
                              {18'd0, rd[`RP_ADC_W-1:0] - prev[`RP_ADC_W-1:0]});
               prev = rd;
            end
         end
         "ramp": begin
            @(posedge adc_clk);
            b_period <= t_data[i];
         end
         default: begin
            $display("unknown operation %0s in golden file for test %0s", t_op[i], t_name[i]);
            errors    = errors + 1;
            test_errs = test_errs + 1;
         end
      endcase
   endtask

   task automatic finish_test(input reg [8*16-1:0] name);
      tests = tests + 1;
      if (test_errs == 0) begin
         $display("test %0s: ok", name);
      end else begin
         $display("test %0s: %0d errors", name, test_errs);
         failed = failed + 1;
      end
      test_errs = 0;
   endtask

   // ----------------------------------------
   // main sequence
   initial begin
      bit            ok;
      integer        i;
      reg [8*16-1:0] cur;
      adc_clk     = 1'b0;
      rst_i       = 1'b1;
      adc_dat_a_i = '0;
      adc_dat_b_i = 14'h2000;                       // mid scale, zero
      sys_addr_i  = '0;
      sys_wdata_i = '0;
      sys_wen_i   = 1'b0;
      sys_ren_i   = 1'b0;
      load_golden(ok);
      if (!ok || n_ops == 0) begin
         $display("could not read any test from verif/rp_golden.txt");
         $display("Simulation FAILED");
         $finish;
      end else begin
         limit = 4 * budget;
         repeat (8) @(posedge adc_clk);
         rst_i <= 1'b0;
         cur = t_name[0];
         for (i = 0; i < n_ops; i = i + 1) begin
            if (t_name[i] != cur) begin
               finish_test(cur);
               cur = t_name[i];
            end
            run_op(i);
         end
         finish_test(cur);
         $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
         if (errors == 0)
            $display("Simulation PASSED");
         else
            $display("Simulation FAILED");
         $finish;
      end
   end

endmodule
